/* all.f */
common/board_io_pkg.sv
logic/input_debouncer.sv
gpio/gpio_registers.sv
display/hex_display.sv
logic/board_io_top.sv
verif/tb_board_io.sv

/* common/board_io_pkg.sv */
package board_io_pkg;

    // processor side of the I/O bus
    typedef logic [7:0]  bus_addr_t;
    typedef logic [31:0] bus_data_t;

    // board pins
    typedef logic [9:0] switch_bits_t;
    // keys are active low at the pins
    typedef logic [3:0] key_bits_t;
    typedef logic [9:0] led_bits_t;

    // raw and debounced inputs share this layout
    typedef struct packed {
        key_bits_t    key;
        switch_bits_t sw;
    } board_inputs_t;

    // six digits of four bits each
    typedef logic [23:0] hex_value_t;
    typedef logic [5:0]  digit_mask_t;

    // one bit per segment from g down to a
    typedef logic [6:0]  segments_t;

    typedef struct packed {
        hex_value_t  hex_value;
        digit_mask_t digit_enable;
    } display_ctrl_t;

    localparam int N_DIGITS = 6;

    // all segments dark
    localparam segments_t SEGMENTS_BLANK = 7'h7F;

    // level of the keys when nobody presses them
    localparam key_bits_t KEYS_RELEASED = 4'hF;

    // word addresses of the register block
    localparam bus_addr_t ADDR_SWITCHES     = 8'h00;
    localparam bus_addr_t ADDR_BUTTONS      = 8'h04;
    localparam bus_addr_t ADDR_RED_LEDS     = 8'h08;
    localparam bus_addr_t ADDR_GREEN_LEDS   = 8'h0C;
    localparam bus_addr_t ADDR_HEX_VALUE    = 8'h10;
    localparam bus_addr_t ADDR_DIGIT_ENABLE = 8'h14;

endpackage

/* display/hex_display.sv */
`timescale 1ns/100ps

module hex_display (
    input  board_io_pkg::display_ctrl_t display,

    output board_io_pkg::segments_t     hex0,
    output board_io_pkg::segments_t     hex1,
    output board_io_pkg::segments_t     hex2,
    output board_io_pkg::segments_t     hex3,
    output board_io_pkg::segments_t     hex4,
    output board_io_pkg::segments_t     hex5
);

    import board_io_pkg::*;

    segments_t digit_seg [N_DIGITS];

    // active low glyphs
    function automatic segments_t glyph(input logic [3:0] nibble);
        segments_t seg;
        case (nibble)
            4'h0:    seg = 7'h40;
            4'h1:    seg = 7'h79;
            4'h2:    seg = 7'h24;
            4'h3:    seg = 7'h30;
            4'h4:    seg = 7'h19;
            4'h5:    seg = 7'h12;
            4'h6:    seg = 7'h02;
            4'h7:    seg = 7'h78;
            4'h8:    seg = 7'h00;
            4'h9:    seg = 7'h10;
            4'hA:    seg = 7'h08;
            // lower case b and d
            4'hB:    seg = 7'h03;
            4'hC:    seg = 7'h46;
            4'hD:    seg = 7'h21;
            4'hE:    seg = 7'h06;
            default: seg = 7'h0E;
        endcase
        return seg;
    endfunction

    always_comb begin
        for (int d = 0; d < N_DIGITS; d++) begin
            if (display.digit_enable[d]) begin
                digit_seg[d] = glyph(display.hex_value[d*4 +: 4]);
            end else begin
                digit_seg[d] = SEGMENTS_BLANK;
            end
        end
    end

    // hex0 is the rightmost digit
    assign hex0 = digit_seg[0];
    assign hex1 = digit_seg[1];
    assign hex2 = digit_seg[2];
    assign hex3 = digit_seg[3];
    assign hex4 = digit_seg[4];
    assign hex5 = digit_seg[5];

endmodule

/* gpio/gpio_registers.sv */
`timescale 1ns/100ps

module gpio_registers (
    input  logic                        clk,
    input  logic                        arst_n,

    input  board_io_pkg::bus_addr_t     bus_addr,
    input  board_io_pkg::bus_data_t     bus_wdata,
    input  logic                        bus_write,
    output board_io_pkg::bus_data_t     bus_rdata,

    input  board_io_pkg::board_inputs_t inputs,

    output board_io_pkg::led_bits_t     red_leds,
    output board_io_pkg::led_bits_t     green_leds,
    output board_io_pkg::display_ctrl_t display
);

    import board_io_pkg::*;

    localparam int LED_W   = $bits(led_bits_t);
    localparam int HEX_W   = $bits(hex_value_t);
    localparam int MASK_W  = $bits(digit_mask_t);
    localparam int SW_W    = $bits(switch_bits_t);
    localparam int KEY_W   = $bits(key_bits_t);

    bus_data_t read_word;

    // write side
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            red_leds   <= '0;
            green_leds <= '0;
            display    <= '0;
        end else if (bus_write) begin
            case (bus_addr)
                ADDR_RED_LEDS: begin
                    red_leds <= bus_wdata[LED_W-1:0];
                end
                ADDR_GREEN_LEDS: begin
                    green_leds <= bus_wdata[LED_W-1:0];
                end
                ADDR_HEX_VALUE: begin
                    display.hex_value <= bus_wdata[HEX_W-1:0];
                end
                ADDR_DIGIT_ENABLE: begin
                    display.digit_enable <= bus_wdata[MASK_W-1:0];
                end
                // input registers and holes ignore writes
                default: begin
                end
            endcase
        end
    end

    // read mux, fields zero extended
    always_comb begin
        read_word = '0;
        case (bus_addr)
            ADDR_SWITCHES: begin
                read_word[SW_W-1:0] = inputs.sw;
            end
            ADDR_BUTTONS: begin
                // pressed key reads as 1
                read_word[KEY_W-1:0] = ~inputs.key;
            end
            ADDR_RED_LEDS: begin
                read_word[LED_W-1:0] = red_leds;
            end
            ADDR_GREEN_LEDS: begin
                read_word[LED_W-1:0] = green_leds;
            end
            ADDR_HEX_VALUE: begin
                read_word[HEX_W-1:0] = display.hex_value;
            end
            ADDR_DIGIT_ENABLE: begin
                read_word[MASK_W-1:0] = display.digit_enable;
            end
            default: begin
                read_word = '0;
            end
        endcase
    end

    // read data lags the address by one cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bus_rdata <= '0;
        end else begin
            bus_rdata <= read_word;
        end
    end

    a_write_known : assert property (
        @(posedge clk) disable iff (!arst_n)
        !$isunknown(bus_write)
    ) else $error("bus_write unknown after reset");

    // a red LED write shows up in the next read of that register
    a_red_readback : assert property (
        @(posedge clk) disable iff (!arst_n)
        bus_write && bus_addr == ADDR_RED_LEDS
            ##1 !bus_write && bus_addr == ADDR_RED_LEDS
        |=> bus_rdata == bus_data_t'($past(bus_wdata[LED_W-1:0], 2))
    ) else $error("red LED read back mismatch");

endmodule

/* logic/board_io_top.sv */
`timescale 1ns/100ps

module board_io_top #(
    parameter int DEBOUNCE_CYCLES = 16
) (
    input  logic                       clk,
    input  logic                       arst_n,

    // board inputs
    input  board_io_pkg::switch_bits_t sw,
    input  board_io_pkg::key_bits_t    key,

    // processor bus
    input  board_io_pkg::bus_addr_t    bus_addr,
    input  board_io_pkg::bus_data_t    bus_wdata,
    input  logic                       bus_write,
    output board_io_pkg::bus_data_t    bus_rdata,

    // board outputs
    output board_io_pkg::led_bits_t    ledr,
    output board_io_pkg::led_bits_t    ledg,
    output board_io_pkg::segments_t    hex0,
    output board_io_pkg::segments_t    hex1,
    output board_io_pkg::segments_t    hex2,
    output board_io_pkg::segments_t    hex3,
    output board_io_pkg::segments_t    hex4,
    output board_io_pkg::segments_t    hex5
);

    import board_io_pkg::*;

    board_inputs_t raw_inputs;
    board_inputs_t debounced_inputs;
    display_ctrl_t display_ctrl;

    assign raw_inputs.key = key;
    assign raw_inputs.sw  = sw;

    input_debouncer #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) u_input_debouncer (
        .clk        (clk),
        .arst_n     (arst_n),
        .raw_in     (raw_inputs),
        .stable_out (debounced_inputs)
    );

    gpio_registers u_gpio_registers (
        .clk        (clk),
        .arst_n     (arst_n),
        .bus_addr   (bus_addr),
        .bus_wdata  (bus_wdata),
        .bus_write  (bus_write),
        .bus_rdata  (bus_rdata),
        .inputs     (debounced_inputs),
        .red_leds   (ledr),
        .green_leds (ledg),
        .display    (display_ctrl)
    );

    // segments follow the display registers directly
    hex_display u_hex_display (
        .display (display_ctrl),
        .hex0    (hex0),
        .hex1    (hex1),
        .hex2    (hex2),
        .hex3    (hex3),
        .hex4    (hex4),
        .hex5    (hex5)
    );

endmodule

/* logic/input_debouncer.sv */
`timescale 1ns/100ps

module input_debouncer #(
    parameter int DEBOUNCE_CYCLES = 16
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  board_io_pkg::board_inputs_t raw_in,
    output board_io_pkg::board_inputs_t stable_out
);

    import board_io_pkg::*;

    localparam int N_BITS = $bits(board_inputs_t);
    localparam int CNT_W  = $clog2(DEBOUNCE_CYCLES + 1);

    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(DEBOUNCE_CYCLES);

    // pins at rest
    localparam board_inputs_t IDLE_LEVEL = '{key: KEYS_RELEASED, sw: '0};

    board_inputs_t sync_meta;
    board_inputs_t sync_q;

    logic [CNT_W-1:0] stable_count [N_BITS];

    // two flops against metastability
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sync_meta <= IDLE_LEVEL;
            sync_q    <= IDLE_LEVEL;
        end else begin
            sync_meta <= raw_in;
            sync_q    <= sync_meta;
        end
    end

    // each bit counts how long it has differed from the output
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < N_BITS; i++) begin
                stable_count[i] <= '0;
            end
            stable_out <= IDLE_LEVEL;
        end else begin
            for (int i = 0; i < N_BITS; i++) begin
                if (sync_q[i] == stable_out[i]) begin
                    // bounced back or already settled
                    stable_count[i] <= '0;
                end else if (stable_count[i] == CNT_MAX) begin
                    stable_count[i] <= '0;
                    stable_out[i]   <= sync_q[i];
                end else begin
                    stable_count[i] <= stable_count[i] + 1'b1;
                end
            end
        end
    end

    // counter must reset before running past its limit
    for (genvar i = 0; i < N_BITS; i++) begin : g_count_check
        a_count_bounded : assert property (
            @(posedge clk) disable iff (!arst_n)
            stable_count[i] <= CNT_MAX
        ) else $error("debounce counter of bit %0d passed its limit", i);
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Compile and run the board I/O testbench with Verilator.
# Exits non-zero unless the simulation prints the pass message.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_board_io \
    -f all.f \
    -o sim_board_io

output=$(./obj_dir/sim_board_io 2>&1) || true
echo "$output"

if echo "$output" | grep -q "TEST PASSED"; then
    exit 0
fi

echo "simulation did not pass"
exit 1

/* verif/tb_board_io.sv */
`timescale 1ns/100ps

module tb_board_io;

    import board_io_pkg::*;

    localparam int DEBOUNCE     = 8;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 5;

    localparam int N_LED_OPS     = 40;
    localparam int N_DISPLAY_OPS = 30;
    localparam int N_INPUT_OPS   = 12;
    localparam int N_GLITCH_OPS  = 8;
    localparam int N_IGNORED_OPS = 20;
    // the reset checks count as a few more
    localparam int N_OPS = N_LED_OPS + N_DISPLAY_OPS + N_INPUT_OPS + N_GLITCH_OPS
                           + N_IGNORED_OPS + 8;

    logic         clk;
    logic         arst_n;
    switch_bits_t sw;
    key_bits_t    key;
    bus_addr_t    bus_addr;
    bus_data_t    bus_wdata;
    logic         bus_write;
    bus_data_t    bus_rdata;
    led_bits_t    ledr;
    led_bits_t    ledg;
    segments_t    hex0;
    segments_t    hex1;
    segments_t    hex2;
    segments_t    hex3;
    segments_t    hex4;
    segments_t    hex5;

    integer seed;
    int     word_errors;
    int     led_errors;
    int     segment_errors;

    // reference state
    led_bits_t    model_red;
    led_bits_t    model_green;
    hex_value_t   model_hex;
    digit_mask_t  model_mask;
    switch_bits_t model_sw;
    key_bits_t    model_key;

    board_io_top #(
        .DEBOUNCE_CYCLES (DEBOUNCE)
    ) UUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .sw        (sw),
        .key       (key),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_write (bus_write),
        .bus_rdata (bus_rdata),
        .ledr      (ledr),
        .ledg      (ledg),
        .hex0      (hex0),
        .hex1      (hex1),
        .hex2      (hex2),
        .hex3      (hex3),
        .hex4      (hex4),
        .hex5      (hex5)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic segments_t glyph_of(input logic [3:0] nibble);
        segments_t seg;
        case (nibble)
            4'h0:    seg = 7'h40;
            4'h1:    seg = 7'h79;
            4'h2:    seg = 7'h24;
            4'h3:    seg = 7'h30;
            4'h4:    seg = 7'h19;
            4'h5:    seg = 7'h12;
            4'h6:    seg = 7'h02;
            4'h7:    seg = 7'h78;
            4'h8:    seg = 7'h00;
            4'h9:    seg = 7'h10;
            4'hA:    seg = 7'h08;
            4'hB:    seg = 7'h03;
            4'hC:    seg = 7'h46;
            4'hD:    seg = 7'h21;
            4'hE:    seg = 7'h06;
            default: seg = 7'h0E;
        endcase
        return seg;
    endfunction

    function automatic segments_t expected_digit(input int d);
        if (model_mask[d]) begin
            return glyph_of(model_hex[d*4 +: 4]);
        end
        return 7'h7F;
    endfunction

    function automatic logic is_mapped(input bus_addr_t addr);
        return addr == ADDR_SWITCHES || addr == ADDR_BUTTONS || addr == ADDR_RED_LEDS
            || addr == ADDR_GREEN_LEDS || addr == ADDR_HEX_VALUE || addr == ADDR_DIGIT_ENABLE;
    endfunction

    function automatic bus_data_t expected_read(input bus_addr_t addr);
        key_bits_t pressed;
        pressed = ~model_key;
        case (addr)
            ADDR_SWITCHES:     return bus_data_t'(model_sw);
            ADDR_BUTTONS:      return bus_data_t'(pressed);
            ADDR_RED_LEDS:     return bus_data_t'(model_red);
            ADDR_GREEN_LEDS:   return bus_data_t'(model_green);
            ADDR_HEX_VALUE:    return bus_data_t'(model_hex);
            ADDR_DIGIT_ENABLE: return bus_data_t'(model_mask);
            default:           return '0;
        endcase
    endfunction

    function automatic void update_model(input bus_addr_t addr, input bus_data_t data);
        case (addr)
            ADDR_RED_LEDS:     model_red   = led_bits_t'(data);
            ADDR_GREEN_LEDS:   model_green = led_bits_t'(data);
            ADDR_HEX_VALUE:    model_hex   = hex_value_t'(data);
            ADDR_DIGIT_ENABLE: model_mask  = digit_mask_t'(data);
            default: begin
            end
        endcase
    endfunction

    task automatic check_word(input string what, input bus_data_t got, input bus_data_t exp);
        if (got !== exp) begin
            $display("ERR %0t: %s: got %h, expected %h", $time, what, got, exp);
            word_errors++;
        end
    endtask

    task automatic check_leds(input string what, input led_bits_t got, input led_bits_t exp);
        if (got !== exp) begin
            $display("ERR %0t: %s: got %h, expected %h", $time, what, got, exp);
            led_errors++;
        end
    endtask

    task automatic check_segments(input string what, input segments_t got,
                                  input segments_t exp);
        if (got !== exp) begin
            $display("ERR %0t: %s: got %h, expected %h", $time, what, got, exp);
            segment_errors++;
        end
    endtask

    task automatic check_outputs();
        check_leds("ledr", ledr, model_red);
        check_leds("ledg", ledg, model_green);
        check_segments("hex0", hex0, expected_digit(0));
        check_segments("hex1", hex1, expected_digit(1));
        check_segments("hex2", hex2, expected_digit(2));
        check_segments("hex3", hex3, expected_digit(3));
        check_segments("hex4", hex4, expected_digit(4));
        check_segments("hex5", hex5, expected_digit(5));
    endtask

    // strobe held for one cycle, outputs settled at the following falling edge
    task automatic write_bus(input bus_addr_t addr, input bus_data_t data);
        @(negedge clk);
        bus_addr  = addr;
        bus_wdata = data;
        bus_write = 1'b1;
        @(negedge clk);
        bus_write = 1'b0;
    endtask

    task automatic read_and_check(input bus_addr_t addr);
        @(negedge clk);
        bus_addr  = addr;
        bus_write = 1'b0;
        @(negedge clk);
        check_word($sformatf("read of address %h", addr), bus_rdata, expected_read(addr));
    endtask

    initial begin
        #((RESET_CYCLES + N_OPS * 40) * CLK_PERIOD);
        $display("timeout: the tests did not finish in the expected time");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        bus_addr_t addr;
        bus_data_t data;
        int        bit_index;
        int        pulse_len;

        seed           = 32'h6226;
        word_errors    = 0;
        led_errors     = 0;
        segment_errors = 0;
        clk            = 1'b0;
        arst_n         = 1'b0;
        sw             = '0;
        key            = 4'hF;
        bus_addr       = '0;
        bus_wdata      = '0;
        bus_write      = 1'b0;
        model_red      = '0;
        model_green    = '0;
        model_hex      = '0;
        model_mask     = '0;
        model_sw       = '0;
        model_key      = 4'hF;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // reset state
        check_outputs();
        read_and_check(ADDR_SWITCHES);
        read_and_check(ADDR_BUTTONS);
        read_and_check(ADDR_RED_LEDS);
        read_and_check(ADDR_GREEN_LEDS);
        read_and_check(ADDR_HEX_VALUE);
        read_and_check(ADDR_DIGIT_ENABLE);

        for (int i = 0; i < N_LED_OPS; i++) begin
            addr = ($random(seed) & 1) ? ADDR_RED_LEDS : ADDR_GREEN_LEDS;
            data = $random(seed);
            write_bus(addr, data);
            update_model(addr, data);
            check_outputs();
            read_and_check(addr);
        end

        for (int i = 0; i < N_DISPLAY_OPS; i++) begin
            data = $random(seed);
            write_bus(ADDR_HEX_VALUE, data);
            update_model(ADDR_HEX_VALUE, data);
            data = $random(seed);
            write_bus(ADDR_DIGIT_ENABLE, data);
            update_model(ADDR_DIGIT_ENABLE, data);
            check_outputs();
            read_and_check(ADDR_HEX_VALUE);
            read_and_check(ADDR_DIGIT_ENABLE);
        end

        // held well past the debounce time
        for (int i = 0; i < N_INPUT_OPS; i++) begin
            @(negedge clk);
            sw  = switch_bits_t'($random(seed));
            key = key_bits_t'($random(seed));
            repeat (DEBOUNCE + 6) @(negedge clk);
            model_sw  = sw;
            model_key = key;
            read_and_check(ADDR_SWITCHES);
            read_and_check(ADDR_BUTTONS);
        end

        // switch read back watched through the pulse and after it
        for (int i = 0; i < N_GLITCH_OPS; i++) begin
            bit_index = {$random(seed)} % $bits(switch_bits_t);
            pulse_len = {$random(seed)} % (DEBOUNCE - 1) + 1;
            @(negedge clk);
            bus_addr  = ADDR_SWITCHES;
            bus_write = 1'b0;
            sw[bit_index] = ~sw[bit_index];
            repeat (pulse_len) begin
                @(negedge clk);
                check_word("switches during glitch", bus_rdata,
                           expected_read(ADDR_SWITCHES));
            end
            sw[bit_index] = ~sw[bit_index];
            repeat (DEBOUNCE + 6) begin
                @(negedge clk);
                check_word("switches after glitch", bus_rdata,
                           expected_read(ADDR_SWITCHES));
            end
        end

        for (int i = 0; i < N_IGNORED_OPS; i++) begin
            case ({$random(seed)} % 3)
                0: addr = ADDR_SWITCHES;
                1: addr = ADDR_BUTTONS;
                default: begin
                    addr = bus_addr_t'($random(seed));
                    while (is_mapped(addr)) begin
                        addr = bus_addr_t'($random(seed));
                    end
                end
            endcase
            data = $random(seed);
            write_bus(addr, data);
            check_outputs();
            read_and_check(addr);
        end

        $display("errors: word %0d, leds %0d, segments %0d",
                 word_errors, led_errors, segment_errors);
        if (word_errors + led_errors + segment_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
